// ==== Makefile ====
# Verilator build and run for the reduction offload tile testbench

TOP       ?= tb_reduction_offload_tile
FILELIST  ?= reduction_offload_tile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb_reduction_model.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code alone is not enough
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== narrow_reduction_alu.sv ====
////////////////////////////////////////////////////////////////////////////
// Narrow reduction ALU
// Integer add, low product, signed max and signed min on the narrow
// offload port, result registered in a pipe stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module narrow_reduction_alu #(
  parameter int narrow_width = 32
) (
  input  wire logic    clk_i,
  input  wire logic    arst_n_i,
  offload_if.engine    port
);

  typedef logic [narrow_width-1:0] narrow_data_t;

  narrow_data_t alu_result;
  logic         a_gt_b;

  assign a_gt_b = $signed(port.operand_a) > $signed(port.operand_b);

  always_comb begin
    case (port.op)
      reduction_pkg::red_add: begin
        alu_result = port.operand_a + port.operand_b;
      end
      // Only the low half of the product is kept
      reduction_pkg::red_mul: begin
        alu_result = port.operand_a * port.operand_b;
      end
      reduction_pkg::red_max: begin
        alu_result = a_gt_b ? port.operand_a : port.operand_b;
      end
      reduction_pkg::red_min: begin
        alu_result = a_gt_b ? port.operand_b : port.operand_a;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  pipe_stage #(
    .payload_t   (narrow_data_t)
  ) i_result_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_data_i   (alu_result),
    .in_valid_i  (port.req_valid),
    .in_ready_o  (port.req_ready),
    .out_data_o  (port.result),
    .out_valid_o (port.resp_valid),
    .out_ready_i (port.resp_ready)
  );

endmodule

`default_nettype wire

// ==== offload_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Offload port bundle
// Request and response of one reduction offload port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface offload_if #(
  parameter int data_width = 32
);

  reduction_pkg::reduction_op_e op;
  logic [data_width-1:0]        operand_a;
  logic [data_width-1:0]        operand_b;
  logic                         req_valid;
  logic                         req_ready;
  logic [data_width-1:0]        result;
  logic                         resp_valid;
  logic                         resp_ready;

  modport router (
    output op, operand_a, operand_b, req_valid, resp_ready,
    input  req_ready, result, resp_valid
  );

  modport engine (
    input  op, operand_a, operand_b, req_valid, resp_ready,
    output req_ready, result, resp_valid
  );

endinterface

`default_nettype wire

// ==== pipe_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Pipe stage
// One-entry valid/ready register, full throughput, generic payload
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  payload_t  in_data_i,
  input  wire logic in_valid_i,
  output logic      in_ready_o,
  output payload_t  out_data_o,
  output logic      out_valid_o,
  input  wire logic out_ready_i
);

  payload_t data_q;
  logic     valid_q;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on an accepted input
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_data_o  = data_q;
  assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== reduction_offload_tile.f ====
+incdir+.
reduction_pkg.sv
offload_if.sv
pipe_stage.sv
narrow_reduction_alu.sv
wide_dca_encoder.sv
reduction_offload_tile.sv
tb_reduction_offload_tile.sv

// ==== reduction_offload_tile.sv ====
////////////////////////////////////////////////////////////////////////////
// Reduction offload tile
// Narrow port served by a local integer ALU, wide port recoded onto
// an external FP64 unit through the DCA port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module reduction_offload_tile #(
  parameter int narrow_width = 32
) (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // Narrow offload port
  input  reduction_pkg::reduction_op_e   narrow_op_i,
  input  wire logic [narrow_width-1:0]   narrow_a_i,
  input  wire logic [narrow_width-1:0]   narrow_b_i,
  input  wire logic                      narrow_req_valid_i,
  output logic                           narrow_req_ready_o,
  output logic [narrow_width-1:0]        narrow_result_o,
  output logic                           narrow_resp_valid_o,
  input  wire logic                      narrow_resp_ready_i,
  // Wide offload port
  input  reduction_pkg::reduction_op_e   wide_op_i,
  input  reduction_pkg::wide_data_t      wide_a_i,
  input  reduction_pkg::wide_data_t      wide_b_i,
  input  wire logic                      wide_req_valid_i,
  output logic                           wide_req_ready_o,
  output reduction_pkg::wide_data_t      wide_result_o,
  output logic                           wide_resp_valid_o,
  input  wire logic                      wide_resp_ready_i,
  // External FP unit
  output reduction_pkg::fpu_op_e         dca_op_code_o,
  output reduction_pkg::fpu_rnd_e        dca_rnd_mode_o,
  output reduction_pkg::wide_data_t      dca_operand0_o,
  output reduction_pkg::wide_data_t      dca_operand1_o,
  output reduction_pkg::wide_data_t      dca_operand2_o,
  output logic                           dca_req_valid_o,
  input  wire logic                      dca_req_ready_i,
  input  reduction_pkg::wide_data_t      dca_result_i,
  input  wire logic                      dca_resp_valid_i,
  output logic                           dca_resp_ready_o
);

  offload_if #(.data_width(narrow_width))              narrow_port ();
  offload_if #(.data_width(reduction_pkg::wide_width)) wide_port ();

  reduction_pkg::dca_req_t dca_req;

  ////////////////////////////////////////////////////////////////////////////
  // Narrow path
  ////////////////////////////////////////////////////////////////////////////

  assign narrow_port.op         = narrow_op_i;
  assign narrow_port.operand_a  = narrow_a_i;
  assign narrow_port.operand_b  = narrow_b_i;
  assign narrow_port.req_valid  = narrow_req_valid_i;
  assign narrow_port.resp_ready = narrow_resp_ready_i;
  assign narrow_req_ready_o     = narrow_port.req_ready;
  assign narrow_result_o        = narrow_port.result;
  assign narrow_resp_valid_o    = narrow_port.resp_valid;

  narrow_reduction_alu #(
    .narrow_width (narrow_width)
  ) i_narrow_alu (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .port         (narrow_port.engine)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Wide path
  ////////////////////////////////////////////////////////////////////////////

  assign wide_port.op         = wide_op_i;
  assign wide_port.operand_a  = wide_a_i;
  assign wide_port.operand_b  = wide_b_i;
  assign wide_port.req_valid  = wide_req_valid_i;
  assign wide_port.resp_ready = wide_resp_ready_i;
  assign wide_req_ready_o     = wide_port.req_ready;
  assign wide_result_o        = wide_port.result;
  assign wide_resp_valid_o    = wide_port.resp_valid;

  wide_dca_encoder i_wide_encoder (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .port             (wide_port.engine),
    .dca_req_o        (dca_req),
    .dca_req_valid_o  (dca_req_valid_o),
    .dca_req_ready_i  (dca_req_ready_i),
    .dca_result_i     (dca_result_i),
    .dca_resp_valid_i (dca_resp_valid_i),
    .dca_resp_ready_o (dca_resp_ready_o)
  );

  // Flatten the request struct onto the DCA pins
  assign dca_op_code_o  = dca_req.op_code;
  assign dca_rnd_mode_o = dca_req.rnd_mode;
  assign dca_operand0_o = dca_req.operands[0];
  assign dca_operand1_o = dca_req.operands[1];
  assign dca_operand2_o = dca_req.operands[2];

endmodule

`default_nettype wire

// ==== reduction_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Reduction offload definitions
// Operation codes, floating-point request encoding and wide data types
// shared by the offload engines and the tile top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package reduction_pkg;

  // Reduction operation carried on both offload ports
  typedef enum logic [1:0] {
    red_add = 2'd0,
    red_mul = 2'd1,
    red_max = 2'd2,
    red_min = 2'd3
  } reduction_op_e;

  // Opcode toward the external FP unit
  typedef enum logic [1:0] {
    fpu_add    = 2'd0,
    fpu_mul    = 2'd1,
    fpu_minmax = 2'd2
  } fpu_op_e;

  // Rounding mode, also selects min or max for fpu_minmax
  typedef enum logic [2:0] {
    rnd_rne = 3'd0,
    rnd_rtz = 3'd1
  } fpu_rnd_e;

  // FP64 operands
  localparam int wide_width = 64;

  typedef logic [wide_width-1:0] wide_data_t;

  // Request to the FP unit, 197 bits
  typedef struct packed {
    fpu_op_e              op_code;
    fpu_rnd_e             rnd_mode;
    wide_data_t [2:0]     operands;
  } dca_req_t;

endpackage

`default_nettype wire

// ==== tb_reduction_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reduction reference model
// Expected narrow ALU results and expected FP unit requests
////////////////////////////////////////////////////////////////////////////

`ifndef TB_REDUCTION_MODEL_SVH
`define TB_REDUCTION_MODEL_SVH

`default_nettype none

function automatic logic [narrow_width-1:0] narrow_model(
  input logic [1:0]              op,
  input logic [narrow_width-1:0] a,
  input logic [narrow_width-1:0] b
);
  logic [2*narrow_width-1:0]      product;
  logic signed [narrow_width-1:0] sa;
  logic signed [narrow_width-1:0] sb;
  product = {{narrow_width{1'b0}}, a} * {{narrow_width{1'b0}}, b};
  sa      = a;
  sb      = b;
  case (op)
    reduction_pkg::red_add: return a + b;
    reduction_pkg::red_mul: return product[narrow_width-1:0];
    reduction_pkg::red_max: return (sa > sb) ? a : b;
    default:                return (sa < sb) ? a : b;
  endcase
endfunction

// Opcode, rounding and operand slots per reduction operation
function automatic reduction_pkg::dca_req_t wide_model(
  input logic [1:0]                op,
  input reduction_pkg::wide_data_t a,
  input reduction_pkg::wide_data_t b
);
  reduction_pkg::dca_req_t req;
  req.op_code     = reduction_pkg::fpu_minmax;
  req.rnd_mode    = reduction_pkg::rnd_rne;
  req.operands[0] = a;
  req.operands[1] = b;
  req.operands[2] = '0;
  case (op)
    reduction_pkg::red_add: begin
      req.op_code     = reduction_pkg::fpu_add;
      req.operands[0] = '0;
      req.operands[1] = a;
      req.operands[2] = b;
    end
    reduction_pkg::red_mul: req.op_code = reduction_pkg::fpu_mul;
    reduction_pkg::red_min: req.rnd_mode = reduction_pkg::rnd_rtz;
    default: req.op_code = reduction_pkg::fpu_minmax;
  endcase
  return req;
endfunction

`default_nettype wire

`endif

// ==== tb_reduction_offload_tile.sv ====
////////////////////////////////////////////////////////////////////////////
// Reduction offload tile testbench
// Random traffic on both ports, an FP unit model on the DCA port and
// queue based checks of every result
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_reduction_offload_tile;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int narrow_width = 32;
  localparam int wait_limit   = 5000;

  typedef logic [narrow_width-1:0] narrow_data_t;
  typedef reduction_pkg::wide_data_t wide_data_t;

  `include "tb_reduction_model.svh"

  logic                         clk_i = 1'b0;
  logic                         arst_n_i;
  reduction_pkg::reduction_op_e narrow_op_i, wide_op_i;
  narrow_data_t                 narrow_a_i, narrow_b_i, narrow_result_o;
  wide_data_t                   wide_a_i, wide_b_i, wide_result_o;
  logic                         narrow_req_valid_i, narrow_req_ready_o;
  logic                         narrow_resp_valid_o, narrow_resp_ready_i;
  logic                         wide_req_valid_i, wide_req_ready_o;
  logic                         wide_resp_valid_o, wide_resp_ready_i;
  reduction_pkg::fpu_op_e       dca_op_code_o;
  reduction_pkg::fpu_rnd_e      dca_rnd_mode_o;
  wide_data_t                   dca_operand0_o, dca_operand1_o, dca_operand2_o;
  logic                         dca_req_valid_o, dca_req_ready_i;
  wide_data_t                   dca_result_i;
  logic                         dca_resp_valid_i, dca_resp_ready_o;

  int      seed;
  int      cycle;
  string   test_name;
  int      test_errors, total_errors, tests_run, tests_failed;
  bit      timed_out;
  // Traffic shape of the running test
  int      narrow_left, wide_left, fp_delay_mask, fp_delay, fp_pending;
  bit      rand_valid, rand_ready, fp_stall, exact_latency;
  // Handshakes seen at the falling edge
  bit      narrow_fire, wide_fire, dca_resp_fire, narrow_held;
  int      narrow_got, wide_got, dca_got, exp_cycle;
  narrow_data_t            held_result, narrow_exp;
  wide_data_t              wide_exp;
  reduction_pkg::dca_req_t dca_exp, dca_act;
  narrow_data_t            narrow_exp_q[$];
  wide_data_t              wide_exp_q[$];
  reduction_pkg::dca_req_t dca_exp_q[$];
  int                      narrow_cyc_q[$], wide_cyc_q[$];

  reduction_offload_tile #(
    .narrow_width (narrow_width)
  ) uut (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .narrow_op_i (narrow_op_i), .narrow_a_i (narrow_a_i), .narrow_b_i (narrow_b_i),
    .narrow_req_valid_i (narrow_req_valid_i), .narrow_req_ready_o (narrow_req_ready_o),
    .narrow_result_o (narrow_result_o), .narrow_resp_valid_o (narrow_resp_valid_o),
    .narrow_resp_ready_i (narrow_resp_ready_i),
    .wide_op_i (wide_op_i), .wide_a_i (wide_a_i), .wide_b_i (wide_b_i),
    .wide_req_valid_i (wide_req_valid_i), .wide_req_ready_o (wide_req_ready_o),
    .wide_result_o (wide_result_o), .wide_resp_valid_o (wide_resp_valid_o),
    .wide_resp_ready_i (wide_resp_ready_i),
    .dca_op_code_o (dca_op_code_o), .dca_rnd_mode_o (dca_rnd_mode_o),
    .dca_operand0_o (dca_operand0_o), .dca_operand1_o (dca_operand1_o),
    .dca_operand2_o (dca_operand2_o),
    .dca_req_valid_o (dca_req_valid_o), .dca_req_ready_i (dca_req_ready_i),
    .dca_result_i (dca_result_i), .dca_resp_valid_i (dca_resp_valid_i),
    .dca_resp_ready_o (dca_resp_ready_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic report_mismatch(input string what, input logic [255:0] exp,
                                 input logic [255:0] act);
    $display("Error: %s %s expected %0h actual %0h", test_name, what, exp, act);
    test_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and FP unit model, one step per clock
  ////////////////////////////////////////////////////////////////////////////

  task automatic fp_unit_step();
    if (dca_resp_fire) begin
      dca_resp_valid_i = 1'b0;
    end
    if (!dca_resp_valid_i && fp_pending > 0) begin
      if (fp_delay > 0) begin
        fp_delay--;
      end else begin
        dca_result_i     = {$random(seed), $random(seed)};
        dca_resp_valid_i = 1'b1;
        wide_exp_q.push_back(dca_result_i);
        fp_pending--;
        fp_delay = $random(seed) & fp_delay_mask;
      end
    end
    dca_req_ready_i = fp_stall ? rand_bit() : 1'b1;
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    @(posedge clk_i);
    #1;
    // Valid holds with its data until the transfer
    if (!narrow_req_valid_i || narrow_fire) begin
      narrow_req_valid_i = 1'b0;
      if (narrow_left > 0 && (!rand_valid || rand_bit())) begin
        r                  = $random(seed);
        narrow_op_i        = reduction_pkg::reduction_op_e'(r[1:0]);
        narrow_a_i         = $random(seed);
        narrow_b_i         = $random(seed);
        narrow_req_valid_i = 1'b1;
        narrow_left--;
      end
    end
    if (!wide_req_valid_i || wide_fire) begin
      wide_req_valid_i = 1'b0;
      if (wide_left > 0 && (!rand_valid || rand_bit())) begin
        r                = $random(seed);
        wide_op_i        = reduction_pkg::reduction_op_e'(r[1:0]);
        wide_a_i         = {$random(seed), $random(seed)};
        wide_b_i         = {$random(seed), $random(seed)};
        wide_req_valid_i = 1'b1;
        wide_left--;
      end
    end
    narrow_resp_ready_i = rand_ready ? rand_bit() : 1'b1;
    wide_resp_ready_i   = rand_ready ? rand_bit() : 1'b1;
    fp_unit_step();
  endtask

  task automatic run_test(input string name, input int n_narrow, input int n_wide,
                          input bit rnd_valid, input bit rnd_ready, input bit stall);
    int waited;
    waited = 0;
    if (!timed_out) begin
      test_name     = name;
      test_errors   = 0;
      rand_valid    = rnd_valid;
      rand_ready    = rnd_ready;
      fp_stall      = stall;
      fp_delay_mask = stall ? 3 : 0;
      exact_latency = !rnd_ready && !stall;
      narrow_left   = n_narrow;
      wide_left     = n_wide;
      narrow_got    = 0;
      wide_got      = 0;
      dca_got       = 0;
      while ((narrow_got < n_narrow || dca_got < n_wide || wide_got < n_wide) && !timed_out) begin
        drive_cycle();
        waited++;
        if (waited > wait_limit) begin
          $display("Timeout in %s: responses stopped after %0d narrow and %0d wide",
                   test_name, narrow_got, wide_got);
          timed_out = 1'b1;
        end
      end
      if (narrow_exp_q.size() + dca_exp_q.size() + wide_exp_q.size() != 0) begin
        report_problem("results left over at the end of the test");
      end
      $display("Test %s finished with %0d errors", test_name, test_errors);
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0 || timed_out) begin
        tests_failed++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checks at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    // The stage takes a request when empty or when its result leaves
    if (narrow_req_ready_o !== (narrow_exp_q.size() == 0 || narrow_resp_ready_i)) begin
      report_problem("narrow request ready does not follow the stage occupancy");
    end
    narrow_fire = narrow_req_valid_i && narrow_req_ready_o;
    if (narrow_fire) begin
      narrow_exp_q.push_back(narrow_model(narrow_op_i, narrow_a_i, narrow_b_i));
      narrow_cyc_q.push_back(cycle);
    end
    if (narrow_held && (!narrow_resp_valid_o || narrow_result_o !== held_result)) begin
      report_problem("narrow result changed while stalled");
    end
    if (narrow_resp_valid_o && narrow_resp_ready_i) begin
      if (narrow_exp_q.size() == 0) begin
        report_problem("narrow result without a request");
      end else begin
        narrow_exp = narrow_exp_q.pop_front();
        exp_cycle  = narrow_cyc_q.pop_front();
        if (narrow_result_o !== narrow_exp) begin
          report_mismatch("narrow result", 256'(narrow_exp), 256'(narrow_result_o));
        end
        if (exact_latency && cycle != exp_cycle + 1) begin
          report_problem("narrow result not one cycle after its request");
        end
        narrow_got++;
      end
    end
    narrow_held = narrow_resp_valid_o && !narrow_resp_ready_i;
    held_result = narrow_result_o;

    if (wide_req_ready_o !== (dca_exp_q.size() == 0 || dca_req_ready_i)) begin
      report_problem("wide request ready does not follow the stage occupancy");
    end
    wide_fire = wide_req_valid_i && wide_req_ready_o;
    if (wide_fire) begin
      dca_exp_q.push_back(wide_model(wide_op_i, wide_a_i, wide_b_i));
      wide_cyc_q.push_back(cycle);
    end
    if (dca_req_valid_o && dca_req_ready_i) begin
      dca_act.op_code     = dca_op_code_o;
      dca_act.rnd_mode    = dca_rnd_mode_o;
      dca_act.operands[0] = dca_operand0_o;
      dca_act.operands[1] = dca_operand1_o;
      dca_act.operands[2] = dca_operand2_o;
      fp_pending++;
      if (dca_exp_q.size() == 0) begin
        report_problem("DCA request without a wide request");
      end else begin
        dca_exp   = dca_exp_q.pop_front();
        exp_cycle = wide_cyc_q.pop_front();
        if (dca_act !== dca_exp) begin
          report_mismatch("DCA request", 256'(dca_exp), 256'(dca_act));
        end
        if (exact_latency && cycle != exp_cycle + 1) begin
          report_problem("DCA request not one cycle after its wide request");
        end
        dca_got++;
      end
    end
    dca_resp_fire = dca_resp_valid_i && dca_resp_ready_o;
    if (dca_resp_ready_o !== wide_resp_ready_i || wide_resp_valid_o !== dca_resp_valid_i) begin
      report_problem("wide response handshake does not follow the DCA port");
    end
    if (wide_resp_valid_o && wide_resp_ready_i) begin
      if (wide_exp_q.size() == 0) begin
        report_problem("wide result without an FP answer");
      end else begin
        wide_exp = wide_exp_q.pop_front();
        if (wide_result_o !== wide_exp) begin
          report_mismatch("wide result", 256'(wide_exp), 256'(wide_result_o));
        end
        wide_got++;
      end
    end
  end

  initial begin
    seed                = 46;
    cycle               = 0;
    arst_n_i            = 1'b0;
    narrow_op_i         = reduction_pkg::red_add;
    narrow_a_i          = '0;
    narrow_b_i          = '0;
    narrow_req_valid_i  = 1'b0;
    narrow_resp_ready_i = 1'b1;
    wide_op_i           = reduction_pkg::red_add;
    wide_a_i            = '0;
    wide_b_i            = '0;
    wide_req_valid_i    = 1'b0;
    wide_resp_ready_i   = 1'b1;
    dca_req_ready_i     = 1'b1;
    dca_result_i        = '0;
    dca_resp_valid_i    = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    test_name   = "reset_state";
    test_errors = 0;
    @(negedge clk_i);
    if (narrow_resp_valid_o !== 1'b0 || dca_req_valid_o !== 1'b0 ||
        wide_resp_valid_o !== 1'b0) begin
      report_problem("a response valid is high right after reset");
    end
    $display("Test %s finished with %0d errors", test_name, test_errors);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end

    run_test("narrow_alu", 200, 0, 1'b0, 1'b0, 1'b0);
    run_test("narrow_backpressure", 200, 0, 1'b1, 1'b1, 1'b0);
    run_test("wide_encoding", 0, 150, 1'b1, 1'b0, 1'b0);
    run_test("wide_response", 0, 150, 1'b1, 1'b1, 1'b1);
    run_test("concurrency", 150, 150, 1'b1, 1'b1, 1'b1);

    $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wide_dca_encoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Wide DCA encoder
// Recodes wide reduction requests into registered FP64 unit requests
// and hands the unit's responses back to the wide port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module wide_dca_encoder (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  offload_if.engine                        port,
  output reduction_pkg::dca_req_t          dca_req_o,
  output logic                             dca_req_valid_o,
  input  wire logic                        dca_req_ready_i,
  input  reduction_pkg::wide_data_t        dca_result_i,
  input  wire logic                        dca_resp_valid_i,
  output logic                             dca_resp_ready_o
);

  reduction_pkg::dca_req_t req_enc;

  always_comb begin
    req_enc             = '0;
    req_enc.op_code     = reduction_pkg::fpu_add;
    req_enc.rnd_mode    = reduction_pkg::rnd_rne;
    req_enc.operands[0] = port.operand_a;
    req_enc.operands[1] = port.operand_b;
    case (port.op)
      // Add uses operands 1 and 2 of the FMA datapath
      reduction_pkg::red_add: begin
        req_enc.operands[0] = '0;
        req_enc.operands[1] = port.operand_a;
        req_enc.operands[2] = port.operand_b;
      end
      reduction_pkg::red_mul: begin
        req_enc.op_code = reduction_pkg::fpu_mul;
      end
      reduction_pkg::red_max: begin
        req_enc.op_code = reduction_pkg::fpu_minmax;
      end
      // RTZ selects min on the minmax unit
      reduction_pkg::red_min: begin
        req_enc.op_code  = reduction_pkg::fpu_minmax;
        req_enc.rnd_mode = reduction_pkg::rnd_rtz;
      end
      default: begin
        req_enc.operands = '0;
      end
    endcase
  end

  pipe_stage #(
    .payload_t   (reduction_pkg::dca_req_t)
  ) i_req_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_data_i   (req_enc),
    .in_valid_i  (port.req_valid),
    .in_ready_o  (port.req_ready),
    .out_data_o  (dca_req_o),
    .out_valid_o (dca_req_valid_o),
    .out_ready_i (dca_req_ready_i)
  );

  // Responses come back in order and pass straight through
  assign port.result      = dca_result_i;
  assign port.resp_valid  = dca_resp_valid_i;
  assign dca_resp_ready_o = port.resp_ready;

endmodule

`default_nettype wire
